// ==== isaPkg.sv ====
`default_nettype none

package isaPkg;

    localparam int WORD_W   = 32;
    localparam int REG_W    = 5;
    localparam int NUM_REGS = 32;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [REG_W-1:0]  regAddr_t;

    // primary opcodes, instr[31:26]
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_ANDI    = 6'h0c;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_XORI    = 6'h0e;
    localparam logic [5:0] OP_LUI     = 6'h0f;

    // function field of SPECIAL, instr[5:0]
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_SLT  = 6'h2a;

    typedef struct packed {
        logic [5:0] opcode;
        regAddr_t   rs;
        regAddr_t   rt;
        regAddr_t   rd;
        logic [4:0] shamt;  // unused by this ALU
        logic [5:0] funct;
    } instrR_t;

    typedef struct packed {
        logic [5:0]  opcode;
        regAddr_t    rs;
        regAddr_t    rt;
        logic [15:0] imm;
    } instrI_t;

    // same word seen as R or I format
    typedef union packed {
        instrR_t r;
        instrI_t i;
    } instr_t;

    typedef enum logic [2:0] {
        ALU_NOP,
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_LUI
    } aluOp_t;

endpackage

`default_nettype wire

// ==== pipePkg.sv ====
`default_nettype none

package pipePkg;

    import isaPkg::*;

    localparam int LANES = 2;  // lane 0 master, lane 1 slave

    // decode to execute, one lane
    typedef struct packed {
        logic     valid;
        aluOp_t   op;
        word_t    opA;
        word_t    opB;   // rt value or extended immediate
        logic     wrEn;
        regAddr_t dest;
    } issue_t;

    // execute result or writeback entry
    typedef struct packed {
        logic     valid;
        logic     wrEn;
        regAddr_t dest;
        word_t    data;
    } result_t;

endpackage

`default_nettype wire

// ==== regFile.sv ====
`default_nettype none

module regFile import isaPkg::*, pipePkg::*; (
    input  logic                     clk,
    input  logic                     reset_i,
    input  regAddr_t [2*LANES-1:0]   rdAddr_i,  // rs0, rt0, rs1, rt1
    output word_t    [2*LANES-1:0]   rdData_o,
    input  result_t  [LANES-1:0]     wr_i
);

    word_t regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                regs[r] <= '0;
            end
        end else begin
            // lane order matters, slave lands last on a shared dest
            for (int l = 0; l < LANES; l++) begin
                if (wr_i[l].valid && wr_i[l].wrEn) begin
                    regs[wr_i[l].dest] <= wr_i[l].data;
                end
            end
        end
    end

    always_comb begin
        for (int p = 0; p < 2*LANES; p++) begin
            if (rdAddr_i[p] == '0) begin
                rdData_o[p] = '0;  // $zero
            end else begin
                rdData_o[p] = regs[rdAddr_i[p]];
            end
        end
    end

endmodule

`default_nettype wire

// ==== decodeStage.sv ====
`default_nettype none

module decodeStage import isaPkg::*, pipePkg::*; (
    input  logic                     clk,
    input  logic                     reset_i,
    input  logic                     instrValid_i,
    input  instr_t                   instr1_i,
    input  instr_t                   instr2_i,
    output regAddr_t [2*LANES-1:0]   rdAddr_o,
    input  word_t    [2*LANES-1:0]   rdData_i,
    input  result_t  [LANES-1:0]     exFwd_i,
    input  result_t  [LANES-1:0]     wbFwd_i,
    output issue_t   [LANES-1:0]     issue_o
);

    logic                 validQ;
    instr_t [LANES-1:0]   instrQ;
    word_t  [LANES-1:0]   rsVal;
    word_t  [LANES-1:0]   rtVal;
    logic   [LANES-1:0]   readsRs;
    logic   [LANES-1:0]   readsRt;
    logic                 pairHazard;

    function automatic logic hits(result_t res, regAddr_t addr);
        return res.valid && res.wrEn && (res.dest != '0) && (res.dest == addr);
    endfunction

    // lowest priority first, later matches override
    function automatic word_t pickOperand(regAddr_t addr, word_t rfData,
                                          result_t [LANES-1:0] ex,
                                          result_t [LANES-1:0] wb);
        word_t val;
        val = rfData;
        for (int l = 0; l < LANES; l++) begin
            if (hits(wb[l], addr)) val = wb[l].data;
        end
        for (int l = 0; l < LANES; l++) begin
            if (hits(ex[l], addr)) val = ex[l].data;
        end
        return val;
    endfunction

    always_ff @(posedge clk) begin
        if (reset_i) begin
            validQ <= 1'b0;
        end else begin
            validQ <= instrValid_i;
        end
        instrQ <= {instr2_i, instr1_i};
    end

    always_comb begin
        for (int l = 0; l < LANES; l++) begin
            rdAddr_o[2*l]   = instrQ[l].r.rs;
            rdAddr_o[2*l+1] = instrQ[l].r.rt;
            rsVal[l] = pickOperand(instrQ[l].r.rs, rdData_i[2*l], exFwd_i, wbFwd_i);
            rtVal[l] = pickOperand(instrQ[l].r.rt, rdData_i[2*l+1], exFwd_i, wbFwd_i);
        end
    end

    always_comb begin
        for (int l = 0; l < LANES; l++) begin
            issue_o[l].valid = validQ;
            issue_o[l].op    = ALU_NOP;
            issue_o[l].opA   = rsVal[l];
            issue_o[l].opB   = rtVal[l];
            issue_o[l].wrEn  = 1'b0;
            issue_o[l].dest  = instrQ[l].r.rd;
            readsRs[l] = 1'b1;
            readsRt[l] = 1'b0;
            if (instrQ[l].r.opcode == OP_SPECIAL) begin
                readsRt[l] = 1'b1;
                issue_o[l].wrEn = validQ;
                case (instrQ[l].r.funct)
                    FN_ADDU: issue_o[l].op = ALU_ADD;
                    FN_SUBU: issue_o[l].op = ALU_SUB;
                    FN_AND:  issue_o[l].op = ALU_AND;
                    FN_OR:   issue_o[l].op = ALU_OR;
                    FN_XOR:  issue_o[l].op = ALU_XOR;
                    FN_SLT:  issue_o[l].op = ALU_SLT;
                    default: begin
                        issue_o[l].wrEn = 1'b0;
                        readsRs[l] = 1'b0;
                        readsRt[l] = 1'b0;
                    end
                endcase
            end else begin
                issue_o[l].dest = instrQ[l].i.rt;  // I-type writes rt
                issue_o[l].wrEn = validQ;
                case (instrQ[l].i.opcode)
                    OP_ADDIU: begin
                        issue_o[l].op  = ALU_ADD;
                        issue_o[l].opB = {{16{instrQ[l].i.imm[15]}}, instrQ[l].i.imm};
                    end
                    OP_ANDI: begin
                        issue_o[l].op  = ALU_AND;
                        issue_o[l].opB = {16'b0, instrQ[l].i.imm};
                    end
                    OP_ORI: begin
                        issue_o[l].op  = ALU_OR;
                        issue_o[l].opB = {16'b0, instrQ[l].i.imm};
                    end
                    OP_XORI: begin
                        issue_o[l].op  = ALU_XOR;
                        issue_o[l].opB = {16'b0, instrQ[l].i.imm};
                    end
                    OP_LUI: begin
                        issue_o[l].op  = ALU_LUI;
                        issue_o[l].opB = {instrQ[l].i.imm, 16'b0};
                        readsRs[l] = 1'b0;
                    end
                    default: begin
                        issue_o[l].wrEn = 1'b0;  // unknown opcode, NOP
                        readsRs[l] = 1'b0;
                    end
                endcase
            end
        end
    end

    // slave must not depend on the master of the same pair
    assign pairHazard = issue_o[0].wrEn && (issue_o[0].dest != '0) &&
                        ((readsRs[1] && (instrQ[1].r.rs == issue_o[0].dest)) ||
                         (readsRt[1] && (instrQ[1].r.rt == issue_o[0].dest)));

    pairRule: assert property (@(posedge clk) disable iff (reset_i)
        instrValid_i |=> !pairHazard)
        else $error("slave reads master destination in one pair");

endmodule

`default_nettype wire

// ==== aluUnit.sv ====
`default_nettype none

module aluUnit import isaPkg::*; (
    input  aluOp_t op_i,
    input  word_t  a_i,
    input  word_t  b_i,
    output word_t  y_o
);

    logic lessThan;

    assign lessThan = $signed(a_i) < $signed(b_i);

    always_comb begin
        case (op_i)
            ALU_ADD: y_o = a_i + b_i;  // wraps, no overflow trap
            ALU_SUB: y_o = a_i - b_i;
            ALU_AND: y_o = a_i & b_i;
            ALU_OR:  y_o = a_i | b_i;
            ALU_XOR: y_o = a_i ^ b_i;
            ALU_SLT: y_o = {{(WORD_W-1){1'b0}}, lessThan};
            ALU_LUI: y_o = b_i;        // already shifted in decode
            default: y_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== executeStage.sv ====
`default_nettype none

module executeStage import isaPkg::*, pipePkg::*; (
    input  logic                  clk,
    input  logic                  reset_i,
    input  issue_t  [LANES-1:0]   issue_i,
    output result_t [LANES-1:0]   exFwd_o,
    output result_t [LANES-1:0]   wb_o
);

    issue_t  [LANES-1:0] issueQ;
    result_t [LANES-1:0] wbQ;
    word_t   [LANES-1:0] aluY;

    always_ff @(posedge clk) begin
        issueQ <= issue_i;
        wbQ    <= exFwd_o;
        if (reset_i) begin
            for (int l = 0; l < LANES; l++) begin
                issueQ[l].valid <= 1'b0;
                issueQ[l].wrEn  <= 1'b0;
                wbQ[l].valid    <= 1'b0;
                wbQ[l].wrEn     <= 1'b0;
            end
        end
    end

    for (genvar l = 0; l < LANES; l++) begin : gLane
        aluUnit alu (
            .op_i (issueQ[l].op),
            .a_i  (issueQ[l].opA),
            .b_i  (issueQ[l].opB),
            .y_o  (aluY[l])
        );

        assign exFwd_o[l] = '{valid: issueQ[l].valid,
                              wrEn:  issueQ[l].wrEn,
                              dest:  issueQ[l].dest,
                              data:  aluY[l]};

        // write enable only ever travels with a live instruction
        wbWrEnValid: assert property (@(posedge clk) disable iff (reset_i)
            wbQ[l].wrEn |-> wbQ[l].valid)
            else $error("writeback lane %0d enabled without valid", l);
    end

    assign wb_o = wbQ;

endmodule

`default_nettype wire

// ==== dualIssueCore.sv ====
`default_nettype none

module dualIssueCore import isaPkg::*, pipePkg::*; (
    input  logic    clk,
    input  logic    reset_i,
    input  logic    instrValid_i,  // one pair per strobe, no back-pressure
    input  instr_t  instr1_i,      // master
    input  instr_t  instr2_i,      // slave
    output result_t wb1_o,
    output result_t wb2_o
);

    regAddr_t [2*LANES-1:0] rdAddr;
    word_t    [2*LANES-1:0] rdData;
    issue_t   [LANES-1:0]   issue;
    result_t  [LANES-1:0]   exFwd;
    result_t  [LANES-1:0]   wb;

    decodeStage decode0 (
        .clk          (clk),
        .reset_i      (reset_i),
        .instrValid_i (instrValid_i),
        .instr1_i     (instr1_i),
        .instr2_i     (instr2_i),
        .rdAddr_o     (rdAddr),
        .rdData_i     (rdData),
        .exFwd_i      (exFwd),
        .wbFwd_i      (wb),
        .issue_o      (issue)
    );

    executeStage execute0 (
        .clk     (clk),
        .reset_i (reset_i),
        .issue_i (issue),
        .exFwd_o (exFwd),
        .wb_o    (wb)
    );

    // writeback register doubles as the write ports
    regFile rf0 (
        .clk      (clk),
        .reset_i  (reset_i),
        .rdAddr_i (rdAddr),
        .rdData_o (rdData),
        .wr_i     (wb)
    );

    assign wb1_o = wb[0];
    assign wb2_o = wb[1];

endmodule

`default_nettype wire

// ==== tbClock.sv ====
`default_nettype none

module tbClock (
    output logic clk_o,
    output logic reset_o
);

    localparam int HALF_PERIOD  = 10;
    localparam int RESET_CYCLES = 8;

    initial begin
        clk_o = 1'b0;
        forever #HALF_PERIOD clk_o = ~clk_o;
    end

    initial begin
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        reset_o = 1'b0;  // released on a falling edge like every other input
    end

endmodule

`default_nettype wire

// ==== tbDualIssue.sv ====
`default_nettype none

module tbDualIssue import isaPkg::*, pipePkg::*; ();

    localparam int DRAIN_LIMIT = 50;

    // one expected writeback and the edge count at which it must show
    typedef struct packed {
        result_t exp;
        int      due;
    } pending_t;

    logic        clk;
    logic        reset;
    logic        instrValid;
    instr_t      instr1;
    instr_t      instr2;
    result_t     wb1;
    result_t     wb2;
    logic        checking;
    int          edges = 0;
    logic [31:0] rngState = 32'd58;
    word_t       model [NUM_REGS];
    pending_t    pendQ [LANES][$];

    tbClock clkGen (
        .clk_o   (clk),
        .reset_o (reset)
    );

    dualIssueCore dut0 (
        .clk          (clk),
        .reset_i      (reset),
        .instrValid_i (instrValid),
        .instr1_i     (instr1),
        .instr2_i     (instr2),
        .wb1_o        (wb1),
        .wb2_o        (wb2)
    );

    always @(posedge clk) edges <= edges + 1;

    task automatic abortRun(input string msg);
        $display("%s", msg);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic checkAddr(input regAddr_t act, input regAddr_t exp, input int l);
        if (act !== exp) begin
            abortRun($sformatf("Fail at time %0t: lane %0d dest %0d, expected %0d",
                               $time, l, act, exp));
        end
    endtask

    task automatic checkWord(input word_t act, input word_t exp, input int l);
        if (act !== exp) begin
            abortRun($sformatf("Fail at time %0t: lane %0d data %h, expected %h",
                               $time, l, act, exp));
        end
    endtask

    task automatic checkResult(input result_t act, input result_t exp, input int l);
        if (act.valid !== 1'b1 || act.wrEn !== exp.wrEn) begin
            abortRun($sformatf("Fail at time %0t: lane %0d valid %b wrEn %b, expected 1 %b",
                               $time, l, act.valid, act.wrEn, exp.wrEn));
        end else if (exp.wrEn) begin
            checkAddr(act.dest, exp.dest, l);
            checkWord(act.data, exp.data, l);
        end
    endtask

    task automatic checkLane(input int l, input result_t act);
        if (pendQ[l].size() > 0 && pendQ[l][0].due == edges) begin
            checkResult(act, pendQ[l][0].exp, l);
            void'(pendQ[l].pop_front());
        end else if (act.valid !== 1'b0) begin
            abortRun($sformatf("Fail at time %0t: lane %0d writeback valid, none expected",
                               $time, l));
        end
    endtask

    // outputs only move on rising edges
    always @(negedge clk) begin
        if (checking) begin
            for (int l = 0; l < LANES; l++) begin
                checkLane(l, (l == 0) ? wb1 : wb2);
            end
        end
    end

    function automatic logic [31:0] nextRandom();
        rngState ^= rngState << 13;
        rngState ^= rngState >> 17;
        rngState ^= rngState << 5;
        return rngState;
    endfunction

    function automatic instr_t rType(logic [5:0] fn, regAddr_t rd, regAddr_t rs,
                                     regAddr_t rt);
        return {OP_SPECIAL, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic instr_t iType(logic [5:0] op, regAddr_t rt, regAddr_t rs,
                                     logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // expected writeback from the ISA rules and the current model
    function automatic result_t evalInstr(instr_t w);
        result_t res;
        word_t   a;
        word_t   b;
        a = model[w.r.rs];
        b = model[w.r.rt];
        res = '{valid: 1'b1, wrEn: 1'b1, dest: w.i.rt, data: '0};
        if (w.r.opcode == OP_SPECIAL) begin
            res.dest = w.r.rd;
            case (w.r.funct)
                FN_ADDU: res.data = a + b;
                FN_SUBU: res.data = a - b;
                FN_AND:  res.data = a & b;
                FN_OR:   res.data = a | b;
                FN_XOR:  res.data = a ^ b;
                FN_SLT:  res.data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                default: res.wrEn = 1'b0;
            endcase
        end else begin
            case (w.i.opcode)
                OP_ADDIU: res.data = a + {{16{w.i.imm[15]}}, w.i.imm};
                OP_ANDI:  res.data = a & {16'h0, w.i.imm};
                OP_ORI:   res.data = a | {16'h0, w.i.imm};
                OP_XORI:  res.data = a ^ {16'h0, w.i.imm};
                OP_LUI:   res.data = {w.i.imm, 16'h0};
                default:  res.wrEn = 1'b0;
            endcase
        end
        return res;
    endfunction

    // does a supported instruction read register r
    function automatic logic readsReg(instr_t w, regAddr_t r);
        result_t probe;
        probe = evalInstr(w);
        if (!probe.wrEn || r == '0) return 1'b0;
        if (w.r.opcode == OP_SPECIAL) return (w.r.rs == r) || (w.r.rt == r);
        return (w.i.opcode != OP_LUI) && (w.i.rs == r);
    endfunction

    task automatic sendPair(input instr_t m, input instr_t s);
        result_t e1;
        result_t e2;
        @(negedge clk);
        e1 = evalInstr(m);
        e2 = evalInstr(s);  // slave never reads the master dest
        if (e1.wrEn && e1.dest != '0) model[e1.dest] = e1.data;
        if (e2.wrEn && e2.dest != '0) model[e2.dest] = e2.data;
        pendQ[0].push_back('{exp: e1, due: edges + 3});
        pendQ[1].push_back('{exp: e2, due: edges + 3});
        instr1 = m;
        instr2 = s;
        instrValid = 1'b1;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(negedge clk);
            instrValid = 1'b0;
        end
    endtask

    task automatic drain();
        int t;
        t = 0;
        idle(1);
        while (pendQ[0].size() + pendQ[1].size() > 0 && t < DRAIN_LIMIT) begin
            @(posedge clk);
            t++;
        end
        if (pendQ[0].size() + pendQ[1].size() > 0) begin
            abortRun("timeout while waiting for the expected writebacks");
        end
    endtask

    task automatic testReset();
        int t;
        t = 0;
        do begin
            @(negedge clk);
            if (wb1.valid !== 1'b0 || wb2.valid !== 1'b0) begin
                abortRun($sformatf("Fail at time %0t: writeback valid during reset", $time));
            end
            @(posedge clk);
            t++;
        end while (reset && t < 40);
        if (reset) abortRun("timeout: reset was never released");
        repeat (2) begin
            @(negedge clk);
            if (wb1.valid !== 1'b0 || wb2.valid !== 1'b0) begin
                abortRun($sformatf("Fail at time %0t: writeback valid after reset", $time));
            end
        end
        @(posedge clk);
        checking = 1'b1;
    endtask

    task automatic testSingleOps();
        logic [5:0]  fns  [6];
        logic [5:0]  ops  [5];
        logic [15:0] imms [4];
        fns  = '{FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_SLT};
        ops  = '{OP_ADDIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI};
        imms = '{16'h7fff, 16'h8000, 16'hffff, 16'h0001};
        // r1 small positive, r2 and r3 negative
        sendPair(iType(OP_ORI, 5'd1, 5'd0, 16'h1234), iType(OP_LUI, 5'd2, 5'd0, 16'h8000));
        sendPair(iType(OP_ORI, 5'd2, 5'd2, 16'h0005), iType(OP_ADDIU, 5'd3, 5'd0, 16'hfffd));
        drain();
        for (int k = 0; k < 6; k++) begin
            sendPair(rType(fns[k], 5'd10, 5'd1, 5'd2), rType(fns[k], 5'd11, 5'd2, 5'd3));
            drain();
        end
        for (int k = 0; k < 5; k++) begin
            for (int j = 0; j < 4; j++) begin
                sendPair(iType(ops[k], 5'd10, 5'd2, imms[j]),
                         iType(ops[k], 5'd11, 5'd3, imms[j]));
                drain();
            end
        end
    endtask

    task automatic testForwarding();
        sendPair(iType(OP_ADDIU, 5'd4, 5'd0, 16'd7), iType(OP_ADDIU, 5'd5, 5'd0, 16'd9));
        sendPair(rType(FN_ADDU, 5'd6, 5'd4, 5'd5), rType(FN_SUBU, 5'd7, 5'd5, 5'd4));
        sendPair(rType(FN_SUBU, 5'd8, 5'd6, 5'd4), rType(FN_XOR, 5'd9, 5'd7, 5'd5));
        sendPair(rType(FN_OR, 5'd12, 5'd8, 5'd6), rType(FN_AND, 5'd13, 5'd9, 5'd7));
        // same regs live in execute and writeback, newest wins
        for (int k = 0; k < 4; k++) begin
            sendPair(iType(OP_ADDIU, 5'd4, 5'd4, 16'd1), iType(OP_ADDIU, 5'd5, 5'd5, 16'hffff));
        end
        sendPair(rType(FN_ADDU, 5'd14, 5'd4, 5'd5), rType(FN_SLT, 5'd15, 5'd5, 5'd4));
        drain();
    endtask

    task automatic testSameDest();
        sendPair(iType(OP_ADDIU, 5'd15, 5'd0, 16'd100), iType(OP_ADDIU, 5'd15, 5'd0, 16'd200));
        sendPair(rType(FN_ADDU, 5'd16, 5'd15, 5'd0), iType(OP_ORI, 5'd17, 5'd15, 16'h0));
        sendPair(iType(OP_ADDIU, 5'd15, 5'd0, 16'd300), iType(OP_ADDIU, 5'd15, 5'd0, 16'd400));
        idle(1);
        sendPair(rType(FN_OR, 5'd16, 5'd15, 5'd0), rType(FN_OR, 5'd17, 5'd0, 5'd15));
        drain();
        sendPair(rType(FN_XOR, 5'd18, 5'd15, 5'd0), iType(OP_ADDIU, 5'd19, 5'd15, 16'd1));
        // $zero stays zero on every path
        sendPair(iType(OP_ADDIU, 5'd0, 5'd0, 16'd55), iType(OP_ORI, 5'd0, 5'd0, 16'h77));
        sendPair(rType(FN_ADDU, 5'd18, 5'd0, 5'd0), iType(OP_ORI, 5'd19, 5'd0, 16'h0));
        sendPair(rType(FN_ADDU, 5'd20, 5'd0, 5'd0), rType(FN_OR, 5'd21, 5'd0, 5'd0));
        drain();
        sendPair(rType(FN_ADDU, 5'd18, 5'd0, 5'd0), iType(OP_XORI, 5'd19, 5'd0, 16'h0));
        drain();
    endtask

    task automatic testUnknown();
        sendPair(iType(OP_ORI, 5'd22, 5'd0, 16'h1111), iType(OP_ORI, 5'd23, 5'd0, 16'h2222));
        drain();
        sendPair(iType(6'h3f, 5'd22, 5'd1, 16'h00ff), rType(6'h3f, 5'd23, 5'd1, 5'd2));
        sendPair(iType(OP_ORI, 5'd24, 5'd22, 16'h0), rType(FN_OR, 5'd25, 5'd23, 5'd0));
        drain();
        sendPair(iType(OP_ORI, 5'd24, 5'd22, 16'h0), rType(FN_OR, 5'd25, 5'd23, 5'd0));
        drain();
    endtask

    function automatic instr_t randomInstr();
        logic [31:0] x;
        regAddr_t    rd;
        regAddr_t    rs;
        regAddr_t    rt;
        instr_t      w;
        x = nextRandom();
        rd = {2'b00, x[2:0]};  // few regs, many dependencies
        rs = {2'b00, x[5:3]};
        rt = {2'b00, x[8:6]};
        case (x[12:9])
            4'd0:    w = rType(FN_ADDU, rd, rs, rt);
            4'd1:    w = rType(FN_SUBU, rd, rs, rt);
            4'd2:    w = rType(FN_AND, rd, rs, rt);
            4'd3:    w = rType(FN_OR, rd, rs, rt);
            4'd4:    w = rType(FN_XOR, rd, rs, rt);
            4'd5:    w = rType(FN_SLT, rd, rs, rt);
            4'd6:    w = iType(OP_ANDI, rt, rs, x[31:16]);
            4'd7:    w = iType(OP_ORI, rt, rs, x[31:16]);
            4'd8:    w = iType(OP_XORI, rt, rs, x[31:16]);
            4'd9:    w = iType(OP_LUI, rt, rs, x[31:16]);
            4'd10:   w = rType(6'h3f, rd, rs, rt);
            4'd11:   w = iType(6'h3e, rt, rs, x[31:16]);
            default: w = iType(OP_ADDIU, rt, rs, x[31:16]);
        endcase
        return w;
    endfunction

    task automatic testRandom();
        instr_t  m;
        instr_t  s;
        result_t em;
        for (int n = 0; n < 200; n++) begin
            m = randomInstr();
            s = randomInstr();
            em = evalInstr(m);
            for (int t = 0; t < 20 && em.wrEn && readsReg(s, em.dest); t++) begin
                s = randomInstr();
            end
            if (em.wrEn && readsReg(s, em.dest)) begin
                s = iType(OP_LUI, 5'd7, 5'd0, 16'h1234);  // reads nothing
            end
            if (nextRandom() % 32'd4 == 32'd0) idle(1);
            sendPair(m, s);
        end
        drain();
    endtask

    initial begin
        repeat (20000) @(posedge clk);
        abortRun("simulation ran too long without finishing");
    end

    initial begin
        instrValid = 1'b0;
        instr1 = '0;
        instr2 = '0;
        checking = 1'b0;
        for (int r = 0; r < NUM_REGS; r++) model[r] = '0;
        testReset();
        testSingleOps();
        testForwarding();
        testSameDest();
        testUnknown();
        testRandom();
        if (pendQ[0].size() == 0 && pendQ[1].size() == 0) begin
            $display("all tests passed");
            $finish;
        end else begin
            abortRun("expected writebacks still pending at the end of the run");
        end
    end

endmodule

`default_nettype wire

// ==== build.f ====
isaPkg.sv
pipePkg.sv
regFile.sv
decodeStage.sv
aluUnit.sv
executeStage.sv
dualIssueCore.sv
tbClock.sv
tbDualIssue.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tbDualIssue
FILELIST  ?= build.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --assert -j 0
PASS_MSG  ?= all tests passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, fail unless it passes"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST OBJDIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) | tee /dev/stderr | grep "$(PASS_MSG)" > /dev/null

clean:
	rm -rf $(OBJDIR)
